/* include/rvPipe_defines.svh */
`ifndef RV_PIPE_DEFINES_SVH
`define RV_PIPE_DEFINES_SVH

// Data path and address width
`define RV_XLEN 32

// Architectural registers, x0 included
`define RV_REGS 32

// Data memory depth in 32-bit words
`define RV_DMEM_WORDS 64

`endif

/* logic/rvPipePkg.sv */
`default_nettype none

package rvPipePkg;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASSB
  } aluOp_t;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rType_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } iType_t;

  // Store immediate is split around rs2/rs1
  typedef struct packed {
    logic [6:0] immHi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] immLo;
    logic [6:0] opcode;
  } sType_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } uType_t;

  typedef union packed {
    rType_t r;
    iType_t i;
    sType_t s;
    uType_t u;
  } instrWord_t;

  localparam logic [6:0] OP_REG   = 7'b0110011;
  localparam logic [6:0] OP_IMM   = 7'b0010011;
  localparam logic [6:0] OP_LUI   = 7'b0110111;
  localparam logic [6:0] OP_AUIPC = 7'b0010111;
  localparam logic [6:0] OP_LOAD  = 7'b0000011;
  localparam logic [6:0] OP_STORE = 7'b0100011;

endpackage

`default_nettype wire

/* logic/idExIf.sv */
`timescale 1ns/10ps
`default_nettype none
`include "rvPipe_defines.svh"

interface idExIf
  import rvPipePkg::*;
();

  logic [`RV_XLEN-1:0]         pc;
  logic [`RV_XLEN-1:0]         lhsValue;
  logic [`RV_XLEN-1:0]         rhsValue;
  logic [$clog2(`RV_REGS)-1:0] lhsIndex;
  logic [$clog2(`RV_REGS)-1:0] rhsIndex;
  logic [$clog2(`RV_REGS)-1:0] writeIndex;
  logic [`RV_XLEN-1:0]         immediate;
  aluOp_t                      aluOp;
  logic                        aluSrc;
  logic                        pcToAlu;
  logic                        memWrite;
  logic                        memRead;
  logic                        regWrite;
  logic                        byteAccess;
  logic                        halfAccess;
  logic                        unsignedLoad;

  modport producer (
    output pc, lhsValue, rhsValue, lhsIndex, rhsIndex, writeIndex, immediate, aluOp,
           aluSrc, pcToAlu, memWrite, memRead, regWrite, byteAccess, halfAccess, unsignedLoad
  );

  // Decode side, register values come from the register file
  modport decoder (
    output pc, lhsIndex, rhsIndex, writeIndex, immediate, aluOp, aluSrc, pcToAlu,
           memWrite, memRead, regWrite, byteAccess, halfAccess, unsignedLoad
  );

  modport consumer (
    input pc, lhsValue, rhsValue, lhsIndex, rhsIndex, writeIndex, immediate, aluOp,
          aluSrc, pcToAlu, memWrite, memRead, regWrite, byteAccess, halfAccess, unsignedLoad
  );

endinterface

`default_nettype wire

/* logic/wbIf.sv */
`timescale 1ns/10ps
`default_nettype none
`include "rvPipe_defines.svh"

interface wbIf;

  logic [`RV_XLEN-1:0]         pc;
  logic [$clog2(`RV_REGS)-1:0] rd;
  logic                        regWrite;
  // Load data already extended, ALU result otherwise
  logic [`RV_XLEN-1:0]         value;

  modport producer (
    output pc, rd, regWrite, value
  );

  modport consumer (
    input pc, rd, regWrite, value
  );

endinterface

`default_nettype wire

/* logic/instrDecoder.sv */
`timescale 1ns/10ps
`default_nettype none
`include "rvPipe_defines.svh"

module instrDecoder
  import rvPipePkg::*;
(
  input wire instrWord_t          instr,
  input wire logic [`RV_XLEN-1:0] pc,
  idExIf.decoder                  id
);

  function automatic aluOp_t aluFor(input logic [2:0] funct3, input logic alt,
                                    input logic isReg);
    aluOp_t op;
    case (funct3)
      3'b000:  op = (isReg && alt) ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    id.pc           = pc;
    id.lhsIndex     = instr.r.rs1;
    id.rhsIndex     = instr.r.rs2;
    id.writeIndex   = instr.r.rd;
    id.immediate    = {{(`RV_XLEN-12){instr.i.imm[11]}}, instr.i.imm};
    id.aluOp        = ALU_ADD;
    id.aluSrc       = 1'b1;
    id.pcToAlu      = 1'b0;
    id.memWrite     = 1'b0;
    id.memRead      = 1'b0;
    id.regWrite     = 1'b0;
    id.byteAccess   = 1'b0;
    id.halfAccess   = 1'b0;
    id.unsignedLoad = 1'b0;

    case (instr.r.opcode)
      OP_REG: begin
        id.aluSrc   = 1'b0;
        id.regWrite = 1'b1;
        id.aluOp    = aluFor(instr.r.funct3, instr.r.funct7[5], 1'b1);
      end
      OP_IMM: begin
        // funct7[5] overlaps imm[10], which marks SRAI
        id.regWrite = 1'b1;
        id.aluOp    = aluFor(instr.i.funct3, instr.r.funct7[5], 1'b0);
      end
      OP_LUI: begin
        id.immediate = {instr.u.imm, 12'b0};
        id.aluOp     = ALU_PASSB;
        id.regWrite  = 1'b1;
      end
      OP_AUIPC: begin
        id.immediate = {instr.u.imm, 12'b0};
        id.pcToAlu   = 1'b1;
        id.regWrite  = 1'b1;
      end
      OP_LOAD: begin
        id.memRead      = 1'b1;
        id.regWrite     = 1'b1;
        id.byteAccess   = instr.i.funct3[1:0] == 2'b00;
        id.halfAccess   = instr.i.funct3[1:0] == 2'b01;
        id.unsignedLoad = instr.i.funct3[2];
      end
      OP_STORE: begin
        id.immediate  = {{(`RV_XLEN-12){instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
        id.memWrite   = 1'b1;
        id.byteAccess = instr.s.funct3[1:0] == 2'b00;
        id.halfAccess = instr.s.funct3[1:0] == 2'b01;
      end
      // Anything else retires as a no-op
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* logic/regFile.sv */
`timescale 1ns/10ps
`default_nettype none
`include "rvPipe_defines.svh"

module regFile (
  input wire logic                        clk,
  input wire logic [$clog2(`RV_REGS)-1:0] lhsIndex,
  input wire logic [$clog2(`RV_REGS)-1:0] rhsIndex,
  output logic [`RV_XLEN-1:0]             lhsValue,
  output logic [`RV_XLEN-1:0]             rhsValue,
  input wire logic                        commit,
  wbIf.consumer                           wb
);

  // x0 has no storage
  logic [`RV_XLEN-1:0] regs [1:`RV_REGS-1];

  always_ff @(posedge clk) begin
    if (commit && wb.rd != '0)
      regs[wb.rd] <= wb.value;
  end

  // Register being committed reads as its new value
  always_comb begin
    lhsValue = '0;
    rhsValue = '0;
    if (lhsIndex != '0)
      lhsValue = (commit && wb.rd == lhsIndex) ? wb.value : regs[lhsIndex];
    if (rhsIndex != '0)
      rhsValue = (commit && wb.rd == rhsIndex) ? wb.value : regs[rhsIndex];
  end

endmodule

`default_nettype wire

/* logic/idExBarrier.sv */
`timescale 1ns/10ps
`default_nettype none

module idExBarrier
  import rvPipePkg::*;
(
  input wire logic clk,
  input wire logic rst,
  input wire logic stall,
  idExIf.consumer  id,
  idExIf.producer  ex
);

  always_ff @(posedge clk) begin
    if (!stall) begin
      ex.pc           <= id.pc;
      ex.lhsValue     <= id.lhsValue;
      ex.rhsValue     <= id.rhsValue;
      ex.lhsIndex     <= id.lhsIndex;
      ex.rhsIndex     <= id.rhsIndex;
      ex.writeIndex   <= id.writeIndex;
      ex.immediate    <= id.immediate;
      ex.aluOp        <= id.aluOp;
      ex.aluSrc       <= id.aluSrc;
      ex.pcToAlu      <= id.pcToAlu;
      ex.memWrite     <= id.memWrite;
      ex.memRead      <= id.memRead;
      ex.regWrite     <= id.regWrite;
      ex.byteAccess   <= id.byteAccess;
      ex.halfAccess   <= id.halfAccess;
      ex.unsignedLoad <= id.unsignedLoad;
    end

    // Control fields only, data fields keep whatever they held
    if (rst) begin
      ex.aluOp        <= ALU_ADD;
      ex.aluSrc       <= 1'b0;
      ex.memWrite     <= 1'b0;
      ex.memRead      <= 1'b0;
      ex.regWrite     <= 1'b0;
      ex.byteAccess   <= 1'b0;
      ex.halfAccess   <= 1'b0;
      ex.unsignedLoad <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* logic/execUnit.sv */
`timescale 1ns/10ps
`default_nettype none
`include "rvPipe_defines.svh"

module execUnit
  import rvPipePkg::*;
(
  idExIf.consumer             ex,
  wbIf.consumer               wb,
  input wire logic            forwardLhs,
  input wire logic            forwardRhs,
  output logic [`RV_XLEN-1:0] aluResult,
  output logic [`RV_XLEN-1:0] storeData
);

  localparam int SHAMT_BITS = $clog2(`RV_XLEN);

  logic [`RV_XLEN-1:0]    lhsFwd;
  logic [`RV_XLEN-1:0]    rhsFwd;
  logic [`RV_XLEN-1:0]    opA;
  logic [`RV_XLEN-1:0]    opB;
  logic [SHAMT_BITS-1:0]  shamt;

  // Writeback value wins over the stale barrier copy
  assign lhsFwd = forwardLhs ? wb.value : ex.lhsValue;
  assign rhsFwd = forwardRhs ? wb.value : ex.rhsValue;

  assign opA   = ex.pcToAlu ? ex.pc : lhsFwd;
  assign opB   = ex.aluSrc ? ex.immediate : rhsFwd;
  assign shamt = opB[SHAMT_BITS-1:0];

  assign storeData = rhsFwd;

  // Loads and stores decode to ALU_ADD, so this is also the byte address
  always_comb begin
    case (ex.aluOp)
      ALU_ADD:   aluResult = opA + opB;
      ALU_SUB:   aluResult = opA - opB;
      ALU_SLL:   aluResult = opA << shamt;
      ALU_SLT:   aluResult = {{(`RV_XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
      ALU_SLTU:  aluResult = {{(`RV_XLEN-1){1'b0}}, opA < opB};
      ALU_XOR:   aluResult = opA ^ opB;
      ALU_SRL:   aluResult = opA >> shamt;
      ALU_SRA:   aluResult = $unsigned($signed(opA) >>> shamt);
      ALU_OR:    aluResult = opA | opB;
      ALU_AND:   aluResult = opA & opB;
      ALU_PASSB: aluResult = opB;
      default:   aluResult = opA + opB;
    endcase
  end

endmodule

`default_nettype wire

/* logic/dataMem.sv */
`timescale 1ns/10ps
`default_nettype none
`include "rvPipe_defines.svh"

module dataMem (
  input wire logic                clk,
  input wire logic                rst,
  input wire logic                stall,
  input wire logic                storeEnable,
  idExIf.consumer                 ex,
  input wire logic [`RV_XLEN-1:0] aluResult,
  input wire logic [`RV_XLEN-1:0] storeData,
  wbIf.producer                   wb
);

  localparam int LANES     = `RV_XLEN / 8;
  localparam int WORD_BITS = $clog2(`RV_DMEM_WORDS);

  logic [`RV_XLEN-1:0]         mem [0:`RV_DMEM_WORDS-1];
  logic [WORD_BITS-1:0]        wordAddr;
  logic [LANES-1:0]            byteEn;
  logic [`RV_XLEN-1:0]         laneData;

  // EX/WB register
  logic [`RV_XLEN-1:0]         wbPc;
  logic [$clog2(`RV_REGS)-1:0] wbRd;
  logic                        wbRegWrite;
  logic                        wbLoad;
  logic                        wbByte;
  logic                        wbHalf;
  logic                        wbUnsigned;
  logic [1:0]                  wbLow;
  logic [`RV_XLEN-1:0]         wbResult;
  logic [`RV_XLEN-1:0]         wbWord;
  logic [7:0]                  loadByte;
  logic [15:0]                 loadHalf;

  assign wordAddr = aluResult[WORD_BITS+1:2];

  always_comb begin
    if (ex.byteAccess) begin
      byteEn   = LANES'(1) << aluResult[1:0];
      laneData = {LANES{storeData[7:0]}};
    end else if (ex.halfAccess) begin
      byteEn   = aluResult[1] ? 4'b1100 : 4'b0011;
      laneData = {(LANES/2){storeData[15:0]}};
    end else begin
      byteEn   = '1;
      laneData = storeData;
    end
  end

  always_ff @(posedge clk) begin
    if (storeEnable) begin
      for (int b = 0; b < LANES; b++) begin
        if (byteEn[b])
          mem[wordAddr][8*b +: 8] <= laneData[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      wbPc       <= ex.pc;
      wbRd       <= ex.writeIndex;
      wbLow      <= aluResult[1:0];
      wbResult   <= aluResult;
      wbRegWrite <= ex.regWrite;
      wbLoad     <= ex.memRead;
      wbByte     <= ex.byteAccess;
      wbHalf     <= ex.halfAccess;
      wbUnsigned <= ex.unsignedLoad;
      if (ex.memRead)
        wbWord <= mem[wordAddr];
    end
    if (rst) begin
      wbRegWrite <= 1'b0;
      wbLoad     <= 1'b0;
      wbByte     <= 1'b0;
      wbHalf     <= 1'b0;
      wbUnsigned <= 1'b0;
    end
  end

  assign loadByte = wbWord[8*wbLow +: 8];
  assign loadHalf = wbWord[16*wbLow[1] +: 16];

  always_comb begin
    if (!wbLoad)
      wb.value = wbResult;
    else if (wbByte)
      wb.value = {{(`RV_XLEN-8){loadByte[7] & ~wbUnsigned}}, loadByte};
    else if (wbHalf)
      wb.value = {{(`RV_XLEN-16){loadHalf[15] & ~wbUnsigned}}, loadHalf};
    else
      wb.value = wbWord;
  end

  assign wb.pc       = wbPc;
  assign wb.rd       = wbRd;
  assign wb.regWrite = wbRegWrite;

endmodule

`default_nettype wire

/* logic/pipeCtrl.sv */
`timescale 1ns/10ps
`default_nettype none

module pipeCtrl (
  input wire logic clk,
  input wire logic rst,
  input wire logic instrValid,
  output logic     instrReady,
  input wire logic retireReady,
  idExIf.consumer  ex,
  wbIf.consumer    wb,
  output logic     stall,
  output logic     exValid,
  output logic     wbValid,
  output logic     forwardLhs,
  output logic     forwardRhs,
  output logic     storeEnable,
  output logic     commit
);

  logic wbWrites;

  // Only a waiting retire can hold the pipe
  assign stall      = wbValid && !retireReady;
  assign instrReady = !stall;

  always_ff @(posedge clk) begin
    if (rst) begin
      exValid <= 1'b0;
      wbValid <= 1'b0;
    end else if (!stall) begin
      exValid <= instrValid && instrReady;
      wbValid <= exValid;
    end
  end

  // A live writer in WB with a real destination
  assign wbWrites = wbValid && wb.regWrite && wb.rd != '0;

  assign forwardLhs = wbWrites && wb.rd == ex.lhsIndex;
  assign forwardRhs = wbWrites && wb.rd == ex.rhsIndex;

  assign storeEnable = exValid && ex.memWrite && !stall;
  assign commit      = wbValid && wb.regWrite && retireReady;

endmodule

`default_nettype wire

/* logic/rvPipeTop.sv */
`timescale 1ns/10ps
`default_nettype none
`include "rvPipe_defines.svh"

module rvPipeTop (
  input wire logic                         clk,
  input wire logic                         rst,
  input wire logic                         instrValid,
  output logic                             instrReady,
  input wire logic [31:0]                  instr,
  input wire logic [`RV_XLEN-1:0]          instrPc,
  output logic                             retireValid,
  input wire logic                         retireReady,
  output logic [`RV_XLEN-1:0]              retirePc,
  output logic [$clog2(`RV_REGS)-1:0]      retireRd,
  output logic                             retireRegWrite,
  output logic [`RV_XLEN-1:0]              retireValue
);

  logic                stall;
  logic                wbValid;
  logic                forwardLhs;
  logic                forwardRhs;
  logic                storeEnable;
  logic                commit;
  logic [`RV_XLEN-1:0] aluResult;
  logic [`RV_XLEN-1:0] storeData;

  idExIf idSide ();
  idExIf exSide ();
  wbIf   wb ();

  instrDecoder decoder (
    .instr (instr),
    .pc    (instrPc),
    .id    (idSide)
  );

  regFile regs (
    .clk      (clk),
    .lhsIndex (idSide.lhsIndex),
    .rhsIndex (idSide.rhsIndex),
    .lhsValue (idSide.lhsValue),
    .rhsValue (idSide.rhsValue),
    .commit   (commit),
    .wb       (wb)
  );

  idExBarrier barrier (
    .clk   (clk),
    .rst   (rst),
    .stall (stall),
    .id    (idSide),
    .ex    (exSide)
  );

  execUnit exec (
    .ex         (exSide),
    .wb         (wb),
    .forwardLhs (forwardLhs),
    .forwardRhs (forwardRhs),
    .aluResult  (aluResult),
    .storeData  (storeData)
  );

  dataMem dmem (
    .clk         (clk),
    .rst         (rst),
    .stall       (stall),
    .storeEnable (storeEnable),
    .ex          (exSide),
    .aluResult   (aluResult),
    .storeData   (storeData),
    .wb          (wb)
  );

  pipeCtrl ctrl (
    .clk         (clk),
    .rst         (rst),
    .instrValid  (instrValid),
    .instrReady  (instrReady),
    .retireReady (retireReady),
    .ex          (exSide),
    .wb          (wb),
    .stall       (stall),
    .exValid     (),
    .wbValid     (wbValid),
    .forwardLhs  (forwardLhs),
    .forwardRhs  (forwardRhs),
    .storeEnable (storeEnable),
    .commit      (commit)
  );

  // Retire port is the WB stage itself
  assign retireValid    = wbValid;
  assign retirePc       = wb.pc;
  assign retireRd       = wb.rd;
  assign retireRegWrite = wb.regWrite;
  assign retireValue    = wb.value;

endmodule

`default_nettype wire

/* testbench/rvPipeChecker.sv */
`timescale 1ns/10ps
`default_nettype none
`include "rvPipe_defines.svh"

module rvPipeChecker (
  input wire logic                        clk,
  input wire logic                        rst,
  input wire logic                        instrReady,
  input wire logic                        retireValid,
  input wire logic                        retireReady,
  input wire logic [`RV_XLEN-1:0]         retirePc,
  input wire logic [$clog2(`RV_REGS)-1:0] retireRd,
  input wire logic                        retireRegWrite,
  input wire logic [`RV_XLEN-1:0]         retireValue
);

  // Expected retirements, oldest first
  logic [`RV_XLEN-1:0]         expPc [$];
  logic [$clog2(`RV_REGS)-1:0] expRd [$];
  logic                        expRegWrite [$];
  logic [`RV_XLEN-1:0]         expValue [$];

  int retireCount = 0;
  int checkCount = 0;
  int errorCount = 0;

  task automatic expectRetire(input logic [`RV_XLEN-1:0] pc,
                              input logic [$clog2(`RV_REGS)-1:0] rd,
                              input logic regWrite, input logic [`RV_XLEN-1:0] value);
    expPc.push_back(pc);
    expRd.push_back(rd);
    expRegWrite.push_back(regWrite);
    expValue.push_back(value);
  endtask

  function automatic int pendingCount();
    return expPc.size();
  endfunction

  task automatic compareField(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("error at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  always @(posedge clk) begin
    logic [`RV_XLEN-1:0]         pc;
    logic [$clog2(`RV_REGS)-1:0] rd;
    logic                        regWrite;
    logic [`RV_XLEN-1:0]         value;
    if (!rst) begin
      // A held retirement must also hold the input side
      if (retireValid && !retireReady && instrReady !== 1'b0) begin
        errorCount++;
        $display("error at %0t: instrReady expected 0, got %b", $time, instrReady);
      end
      if (retireValid && retireReady) begin
        retireCount++;
        if (expPc.size() == 0) begin
          errorCount++;
          $display("at %0t an instruction retired that was never issued or already retired",
                   $time);
        end else begin
          pc       = expPc.pop_front();
          rd       = expRd.pop_front();
          regWrite = expRegWrite.pop_front();
          value    = expValue.pop_front();
          compareField("retirePc", pc, retirePc);
          compareField("retireRegWrite", 32'(regWrite), 32'(retireRegWrite));
          // Stores have no destination, their rd bits are immediate bits
          if (regWrite)
            compareField("retireRd", 32'(rd), 32'(retireRd));
          compareField("retireValue", value, retireValue);
        end
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/rvPipeTb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "rvPipe_defines.svh"

module rvPipeTb
  import rvPipePkg::*;
();

  localparam int RANDOM_COUNT = 2000;
  localparam int WAIT_LIMIT   = 200;
  localparam int MEM_BYTES    = `RV_DMEM_WORDS * 4;
  localparam int WORD_MSB     = $clog2(`RV_DMEM_WORDS) + 1;

  logic                        clk;
  logic                        rst;
  logic                        instrValid;
  logic                        instrReady;
  logic [31:0]                 instr;
  logic [`RV_XLEN-1:0]         instrPc;
  logic                        retireValid;
  logic                        retireReady;
  logic [`RV_XLEN-1:0]         retirePc;
  logic [$clog2(`RV_REGS)-1:0] retireRd;
  logic                        retireRegWrite;
  logic [`RV_XLEN-1:0]         retireValue;

  logic [31:0]         rngState;
  logic [`RV_XLEN-1:0] modelRegs [0:`RV_REGS-1];
  logic [`RV_XLEN-1:0] modelMem [0:`RV_DMEM_WORDS-1];
  logic [`RV_XLEN-1:0] nextPc;
  logic                backPressure;
  int                  tbErrors;
  int                  errorsBefore;

  rvPipeTop DUT (
    .clk            (clk),
    .rst            (rst),
    .instrValid     (instrValid),
    .instrReady     (instrReady),
    .instr          (instr),
    .instrPc        (instrPc),
    .retireValid    (retireValid),
    .retireReady    (retireReady),
    .retirePc       (retirePc),
    .retireRd       (retireRd),
    .retireRegWrite (retireRegWrite),
    .retireValue    (retireValue)
  );

  rvPipeChecker retireCheck (
    .clk            (clk),
    .rst            (rst),
    .instrReady     (instrReady),
    .retireValid    (retireValid),
    .retireReady    (retireReady),
    .retirePc       (retirePc),
    .retireRd       (retireRd),
    .retireRegWrite (retireRegWrite),
    .retireValue    (retireValue)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] nextRand();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  // Mostly x0..x7 so results get reused right away
  function automatic logic [4:0] pickReg();
    logic [31:0] r;
    r = nextRand();
    return (r[1:0] == 2'b00) ? r[12:8] : {2'b00, r[10:8]};
  endfunction

  function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
    logic [31:0] y;
    case (f3)
      3'b000:  y = alt ? a - b : a + b;
      3'b001:  y = a << b[4:0];
      3'b010:  y = {31'b0, $signed(a) < $signed(b)};
      3'b011:  y = {31'b0, a < b};
      3'b100:  y = a ^ b;
      3'b101: begin
        if (alt)
          y = $signed(a) >>> b[4:0];
        else
          y = a >> b[4:0];
      end
      3'b110:  y = a | b;
      default: y = a & b;
    endcase
    return y;
  endfunction

  function automatic logic [31:0] randomInstr();
    logic [31:0] r;
    logic [31:0] word;
    logic [2:0]  f3;
    logic [1:0]  size;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  base;
    logic [11:0] imm;
    logic [7:0]  addr;
    int          kind;
    r    = nextRand();
    kind = int'(nextRand() % 10);
    f3   = r[6:4];
    rd   = pickReg();
    rs1  = pickReg();
    rs2  = pickReg();
    // Small positive immediates keep some registers usable as bases
    imm  = r[7] ? {4'b0, r[27:20]} : r[31:20];
    size = 2'(r[9:8] % 3);
    addr = r[31:24] & ~((8'd1 << size) - 8'd1);
    base = (modelRegs[rs1] < MEM_BYTES) ? rs1 : 5'd0;
    case (kind)
      0, 1, 2: begin
        word = {((f3 == 3'b000 || f3 == 3'b101) && r[10]) ? 7'h20 : 7'h00,
                rs2, rs1, f3, rd, OP_REG};
      end
      3, 4: begin
        if (f3 == 3'b001 || f3 == 3'b101)
          imm = {1'b0, f3[2] & r[10], 5'b0, r[24:20]};
        word = {imm, rs1, f3, rd, OP_IMM};
      end
      5: word = {r[31:12], rd, OP_LUI};
      6: word = {r[31:12], rd, OP_AUIPC};
      default: begin
        imm = 12'(addr) - modelRegs[base][11:0];
        if (kind == 9)
          word = {imm[11:5], rs2, base, 1'b0, size, imm[4:0], OP_STORE};
        else
          word = {imm, base, (size != 2'd2) && r[11], size, rd, OP_LOAD};
      end
    endcase
    return word;
  endfunction

  task automatic applyModel(input logic [31:0] word, input logic [`RV_XLEN-1:0] pc);
    logic [2:0]          f3;
    logic [4:0]          rd;
    logic [31:0]         a;
    logic [31:0]         b;
    logic [31:0]         addr;
    logic [31:0]         shifted;
    logic [31:0]         value;
    logic [WORD_MSB-2:0] idx;
    logic                writes;
    f3      = word[14:12];
    rd      = word[11:7];
    a       = modelRegs[word[19:15]];
    b       = modelRegs[word[24:20]];
    writes  = 1'b1;
    value   = '0;
    addr    = a + {{20{word[31]}}, word[31:20]};
    if (word[6:0] == OP_STORE)
      addr = a + {{20{word[31]}}, word[31:25], word[11:7]};
    idx     = addr[WORD_MSB:2];
    shifted = modelMem[idx] >> (8 * addr[1:0]);
    case (word[6:0])
      OP_REG:   value = aluModel(f3, word[30], a, b);
      OP_IMM:   value = aluModel(f3, word[30] && f3 == 3'b101, a,
                                 {{20{word[31]}}, word[31:20]});
      OP_LUI:   value = {word[31:12], 12'b0};
      OP_AUIPC: value = pc + {word[31:12], 12'b0};
      OP_LOAD: begin
        case (f3)
          3'b000:  value = {{24{shifted[7]}}, shifted[7:0]};
          3'b001:  value = {{16{shifted[15]}}, shifted[15:0]};
          3'b100:  value = {24'b0, shifted[7:0]};
          3'b101:  value = {16'b0, shifted[15:0]};
          default: value = shifted;
        endcase
      end
      default: begin
        writes = 1'b0;
        value  = addr;
        if (f3 == 3'b000)
          modelMem[idx][8*addr[1:0] +: 8] = b[7:0];
        else if (f3 == 3'b001)
          modelMem[idx][8*addr[1:0] +: 16] = b[15:0];
        else
          modelMem[idx] = b;
      end
    endcase
    if (writes && rd != 5'd0)
      modelRegs[rd] = value;
    retireCheck.expectRetire(pc, rd, writes, value);
  endtask

  task automatic timeout(input string what);
    $display("timeout at %0t: %s", $time, what);
    $display("Result: FAILED");
    $finish;
  endtask

  task automatic driveRetireReady();
    retireReady = backPressure ? (nextRand() % 10 >= 3) : 1'b1;
  endtask

  // Holds the word on the port until the DUT takes it
  task automatic sendInstr(input logic [31:0] word, input logic forceValid);
    int   tries;
    logic accepted;
    tries    = 0;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      driveRetireReady();
      instrValid = forceValid || (nextRand() % 4 != 0);
      instr      = word;
      instrPc    = nextPc;
      #1;
      accepted = instrValid && instrReady;
      if (accepted) begin
        applyModel(word, nextPc);
        nextPc = nextPc + 4;
      end
      tries++;
      if (tries > WAIT_LIMIT)
        timeout("instrReady stayed low, an instruction was never accepted");
    end
  endtask

  task automatic drainPipe();
    int cycles;
    cycles = 0;
    while (retireCheck.pendingCount() != 0 || retireValid) begin
      @(negedge clk);
      instrValid = 1'b0;
      driveRetireReady();
      cycles++;
      if (cycles > WAIT_LIMIT)
        timeout("retire handshakes stopped with instructions still expected");
    end
  endtask

  task automatic endTest(input string name);
    int errs;
    errs = retireCheck.errorCount + tbErrors - errorsBefore;
    $display("%s: %s, %0d errors", name, (errs == 0) ? "ok" : "failing", errs);
    errorsBefore = retireCheck.errorCount + tbErrors;
  endtask

  initial begin
    logic [31:0] r;
    logic [11:0] imm;
    int          cycles;
    clk          = 1'b0;
    rst          = 1'b1;
    instrValid   = 1'b0;
    instr        = '0;
    instrPc      = '0;
    retireReady  = 1'b1;
    backPressure = 1'b0;
    rngState     = 32'h82d5;
    nextPc       = 32'h1000;
    tbErrors     = 0;
    errorsBefore = 0;
    for (int k = 0; k < `RV_REGS; k++)
      modelRegs[k] = '0;

    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    @(negedge clk);
    if (retireValid !== 1'b0) begin
      tbErrors++;
      $display("error at %0t: retireValid expected 0, got %b", $time, retireValid);
    end
    if (instrReady !== 1'b1) begin
      tbErrors++;
      $display("error at %0t: instrReady expected 1, got %b", $time, instrReady);
    end
    endTest("reset state");

    // Every register gets a small known value
    for (int k = 1; k < `RV_REGS; k++) begin
      r = nextRand();
      sendInstr({4'b0, r[7:0], 5'd0, 3'b000, 5'(k), OP_IMM}, 1'b1);
    end
    drainPipe();
    endTest("register setup");

    for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
      r   = nextRand();
      imm = 12'(i * 4);
      sendInstr({r[31:12], 5'd5, OP_LUI}, 1'b1);
      sendInstr({r[11:0], 5'd5, 3'b000, 5'd5, OP_IMM}, 1'b1);
      sendInstr({imm[11:5], 5'd5, 5'd0, 3'b010, imm[4:0], OP_STORE}, 1'b1);
    end
    drainPipe();
    endTest("memory fill");

    backPressure = 1'b1;
    for (int i = 0; i < RANDOM_COUNT; i++)
      sendInstr(randomInstr(), 1'b0);
    drainPipe();
    endTest("random mix with back-pressure");

    // Lone ADDI into an idle pipe
    backPressure = 1'b0;
    sendInstr({12'd1, 5'd0, 3'b000, 5'd1, OP_IMM}, 1'b1);
    cycles = 0;
    while (!retireValid) begin
      @(negedge clk);
      instrValid = 1'b0;
      cycles++;
      if (cycles > WAIT_LIMIT)
        timeout("retireValid never rose for the lone instruction");
    end
    if (cycles != 2) begin
      tbErrors++;
      $display("error at %0t: retire latency expected 2, got %0d", $time, cycles);
    end
    drainPipe();
    endTest("retire latency");

    $display("summary: %0d retired, %0d field checks, %0d errors",
             retireCheck.retireCount, retireCheck.checkCount,
             retireCheck.errorCount + tbErrors);
    if (retireCheck.errorCount + tbErrors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* rvPipe.f */
+incdir+include
logic/rvPipePkg.sv
logic/idExIf.sv
logic/wbIf.sv
logic/instrDecoder.sv
logic/regFile.sv
logic/idExBarrier.sv
logic/execUnit.sv
logic/dataMem.sv
logic/pipeCtrl.sv
logic/rvPipeTop.sv
testbench/rvPipeChecker.sv
testbench/rvPipeTb.sv
